/* int_pkg.sv */
// int_pkg: shared Q8.8 fixed-point, ray, triangle and pipeline types for the intersection unit
`default_nettype none

package int_pkg;

  // signed Q8.8, one is 256
  typedef logic signed [15:0] fix_t;

  localparam fix_t FIX_ONE = 16'sd256;

  // pipeline latencies in cycles
  localparam int PRIME_LAT = 2;
  localparam int TUV_LAT   = 2;
  localparam int MATH_LAT  = PRIME_LAT + TUV_LAT;
  // plus the output register in hit_select
  localparam int INT_LAT   = MATH_LAT + 1;

  typedef struct packed {
    fix_t x;
    fix_t y;
    fix_t z;
  } vec3_t;

  typedef struct packed {
    vec3_t      origin;
    vec3_t      dir;
    fix_t       t_max;
    logic [7:0] ray_id;
  } ray_t;

  // m[row][col], col 3 is the translation
  typedef struct packed {
    fix_t [2:0][3:0] m;
    logic [15:0]     tri_id;
  } int_cacheline_t;

  // ray in unit triangle space
  typedef struct packed {
    vec3_t originp;
    vec3_t dirp;
  } prime_t;

  typedef struct packed {
    fix_t u;
    fix_t v;
  } bari_uv_t;

  typedef struct packed {
    fix_t     t;
    logic     t_valid;
    logic     bari_hit;
    bari_uv_t uv;
  } tuv_t;

  // rides beside the math
  typedef struct packed {
    ray_t        ray;
    logic [15:0] tri0_id;
    logic [15:0] tri1_id;
  } int_pipe_t;

  typedef struct packed {
    logic [15:0] tri_id;
    fix_t        t_int;
    vec3_t       p_int;
    bari_uv_t    uv;
  } intersection_t;

  typedef enum logic [1:0] {
    SEL_NONE,
    SEL_TRI0,
    SEL_TRI1
  } hit_sel_e;

  // 32 bit product, arithmetic shift by 8, keep low 16 bits
  function automatic fix_t fix_mul(input fix_t a, input fix_t b);
    logic signed [31:0] prod;
    logic signed [31:0] shifted;
    prod    = a * b;
    shifted = prod >>> 8;
    return shifted[15:0];
  endfunction

endpackage

`default_nettype wire

/* delay_line.sv */
// delay_line: fixed latency register chain for data that rides beside the math
`timescale 1ns/10ps
`default_nettype none

module delay_line #(
  parameter int LAT   = 2,
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [WIDTH-1:0] data_in,
  output logic [WIDTH-1:0] data_out
);

  // stage[0] is the newest entry
  logic [WIDTH-1:0] stage [LAT];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < LAT; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= data_in;
      for (int i = 1; i < LAT; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign data_out = stage[LAT-1];

endmodule

`default_nettype wire

/* prime_calc.sv */
// prime_calc: two-stage affine transform of ray origin and direction into unit triangle space
`timescale 1ns/10ps
`default_nettype none

module prime_calc (
  input  logic                    clk,
  input  logic                    rst,
  input  int_pkg::ray_t           ray_in,
  input  int_pkg::int_cacheline_t tri_in,
  output int_pkg::prime_t         prime_out
);
  import int_pkg::*;

  // origin in homogeneous form, w = one
  fix_t [3:0]      org_h;
  fix_t [2:0]      dir_v;
  // stage one product registers
  fix_t [2:0][3:0] org_prod;
  fix_t [2:0][2:0] dir_prod;
  // stage two row sums
  fix_t [2:0]      org_sum;
  fix_t [2:0]      dir_sum;

  always_comb begin
    org_h[0] = ray_in.origin.x;
    org_h[1] = ray_in.origin.y;
    org_h[2] = ray_in.origin.z;
    // times one picks up the translation column unchanged
    org_h[3] = FIX_ONE;
    dir_v[0] = ray_in.dir.x;
    dir_v[1] = ray_in.dir.y;
    dir_v[2] = ray_in.dir.z;
  end

  // stage one, 12 origin products and 9 direction products
  always_ff @(posedge clk) begin
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < 4; c++) begin
        org_prod[r][c] <= fix_mul(tri_in.m[r][c], org_h[c]);
      end
      // direction skips the translation
      for (int c = 0; c < 3; c++) begin
        dir_prod[r][c] <= fix_mul(tri_in.m[r][c], dir_v[c]);
      end
    end
  end

  // row sums, wrapping at 16 bits
  always_comb begin
    for (int r = 0; r < 3; r++) begin
      org_sum[r] = org_prod[r][0] + org_prod[r][1] + org_prod[r][2] + org_prod[r][3];
      dir_sum[r] = dir_prod[r][0] + dir_prod[r][1] + dir_prod[r][2];
    end
  end

  // stage two
  always_ff @(posedge clk) begin
    if (rst) begin
      prime_out <= '0;
    end else begin
      prime_out.originp.x <= org_sum[0];
      prime_out.originp.y <= org_sum[1];
      prime_out.originp.z <= org_sum[2];
      prime_out.dirp.x    <= dir_sum[0];
      prime_out.dirp.y    <= dir_sum[1];
      prime_out.dirp.z    <= dir_sum[2];
    end
  end

endmodule

`default_nettype wire

/* tuv_calc.sv */
// tuv_calc: two-stage hit distance, barycentric u and v, and unit triangle inside test
`timescale 1ns/10ps
`default_nettype none

module tuv_calc (
  input  logic            clk,
  input  logic            rst,
  input  int_pkg::prime_t prime_in,
  input  int_pkg::fix_t   t_max,
  output int_pkg::tuv_t   tuv_out
);
  import int_pkg::*;

  // stage one comb
  fix_t               neg_oz;
  logic signed [23:0] num;
  logic signed [23:0] quot;
  logic               dz_nonzero;
  fix_t               t_c;
  logic               t_valid_c;
  // stage one registers
  fix_t               t_q;
  logic               t_valid_q;
  fix_t               ox_q;
  fix_t               oy_q;
  fix_t               dx_q;
  fix_t               dy_q;
  // stage two comb
  fix_t               u_c;
  fix_t               v_c;
  fix_t               uv_sum;
  logic               inside_c;

  // plane z = 0 crossing, t = -oz / dz in Q8.8
  always_comb begin
    // negate wraps at 16 bits
    neg_oz     = -prime_in.originp.z;
    num        = {neg_oz, 8'h00};
    dz_nonzero = (prime_in.dirp.z != 16'sd0);
    // signed divide truncates toward zero, guard the zero divisor
    if (dz_nonzero) begin
      quot = num / prime_in.dirp.z;
    end else begin
      quot = '0;
    end
    t_c       = quot[15:0];
    t_valid_c = dz_nonzero && (t_c > 16'sd0) && (t_c < t_max);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      t_valid_q <= 1'b0;
    end else begin
      t_valid_q <= t_valid_c;
    end
  end

  // x and y ride along for the projection
  always_ff @(posedge clk) begin
    t_q  <= t_c;
    ox_q <= prime_in.originp.x;
    oy_q <= prime_in.originp.y;
    dx_q <= prime_in.dirp.x;
    dy_q <= prime_in.dirp.y;
  end

  // hit point in the unit triangle plane
  always_comb begin
    u_c      = ox_q + fix_mul(t_q, dx_q);
    v_c      = oy_q + fix_mul(t_q, dy_q);
    // sum wraps at 16 bits like every other sum
    uv_sum   = u_c + v_c;
    inside_c = (u_c >= 16'sd0) && (v_c >= 16'sd0) && (uv_sum <= FIX_ONE);
  end

  // stage two
  always_ff @(posedge clk) begin
    if (rst) begin
      tuv_out <= '0;
    end else begin
      tuv_out.t        <= t_q;
      tuv_out.t_valid  <= t_valid_q;
      tuv_out.bari_hit <= inside_c;
      tuv_out.uv.u     <= u_c;
      tuv_out.uv.v     <= v_c;
    end
  end

endmodule

`default_nettype wire

/* hit_select.sv */
// hit_select: picks the nearer valid triangle hit and registers the intersection record
`timescale 1ns/10ps
`default_nettype none

module hit_select (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   valid_in,
  input  int_pkg::tuv_t          tuv0,
  input  int_pkg::tuv_t          tuv1,
  input  int_pkg::int_pipe_t     pipe_in,
  output logic                   valid_out,
  output logic                   hit_out,
  output int_pkg::ray_t          ray_out,
  output int_pkg::intersection_t intersection_out
);
  import int_pkg::*;

  logic          hit0;
  logic          hit1;
  hit_sel_e      sel;
  // winning triangle's fields
  logic [15:0]   id_w;
  fix_t          t_w;
  bari_uv_t      uv_w;
  intersection_t isect_c;

  // classify the ray
  always_comb begin
    hit0 = tuv0.t_valid & tuv0.bari_hit;
    hit1 = tuv1.t_valid & tuv1.bari_hit;
    if (!valid_in) begin
      sel = SEL_NONE;
    end else if (hit0 && hit1) begin
      // nearer wins, tie goes to tri0
      sel = (tuv1.t < tuv0.t) ? SEL_TRI1 : SEL_TRI0;
    end else if (hit0) begin
      sel = SEL_TRI0;
    end else if (hit1) begin
      sel = SEL_TRI1;
    end else begin
      sel = SEL_NONE;
    end
  end

  // mux the winner, then hit point along the ray
  always_comb begin
    case (sel)
      SEL_TRI0: begin
        id_w = pipe_in.tri0_id;
        t_w  = tuv0.t;
        uv_w = tuv0.uv;
      end
      SEL_TRI1: begin
        id_w = pipe_in.tri1_id;
        t_w  = tuv1.t;
        uv_w = tuv1.uv;
      end
      default: begin
        id_w = '0;
        t_w  = '0;
        uv_w = '0;
      end
    endcase
    isect_c.tri_id  = id_w;
    isect_c.t_int   = t_w;
    isect_c.uv      = uv_w;
    isect_c.p_int.x = pipe_in.ray.origin.x + fix_mul(t_w, pipe_in.ray.dir.x);
    isect_c.p_int.y = pipe_in.ray.origin.y + fix_mul(t_w, pipe_in.ray.dir.y);
    isect_c.p_int.z = pipe_in.ray.origin.z + fix_mul(t_w, pipe_in.ray.dir.z);
    // miss gives an all zero record
    if (sel == SEL_NONE) begin
      isect_c = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_out <= 1'b0;
      hit_out   <= 1'b0;
    end else begin
      valid_out <= valid_in;
      hit_out   <= valid_in && (sel != SEL_NONE);
    end
  end

  // result payload
  always_ff @(posedge clk) begin
    ray_out          <= pipe_in.ray;
    intersection_out <= isect_c;
  end

endmodule

`default_nettype wire

/* int_math.sv */
// int_math: pipelined two-triangle ray intersection unit, prime and tuv math plus hit select
`timescale 1ns/10ps
`default_nettype none

module int_math (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    valid_in,
  input  int_pkg::ray_t           ray_in,
  input  int_pkg::int_cacheline_t tri0_in,
  input  int_pkg::int_cacheline_t tri1_in,
  output logic                    valid_out,
  output logic                    hit_out,
  output int_pkg::ray_t           ray_out,
  output int_pkg::intersection_t  intersection_out
);
  import int_pkg::*;

  // ray in each triangle's space
  prime_t                     prime0;
  prime_t                     prime1;
  tuv_t                       tuv_res0;
  tuv_t                       tuv_res1;
  // t_max lined up with prime_calc output
  fix_t                       t_max_d;
  // side band, valid in the top bit
  int_pipe_t                  pipe_in;
  int_pipe_t                  pipe_math;
  logic                       valid_math;
  logic [$bits(int_pipe_t):0] side_in;
  logic [$bits(int_pipe_t):0] side_out;

  assign pipe_in = '{ray: ray_in, tri0_id: tri0_in.tri_id, tri1_id: tri1_in.tri_id};
  assign side_in = {valid_in, pipe_in};
  assign {valid_math, pipe_math} = side_out;

  prime_calc pc0 (.clk, .rst, .ray_in, .tri_in(tri0_in), .prime_out(prime0));
  prime_calc pc1 (.clk, .rst, .ray_in, .tri_in(tri1_in), .prime_out(prime1));

  // tap for the t range test in tuv stage one
  delay_line #(.LAT(PRIME_LAT), .WIDTH($bits(fix_t))) tmax_dl (
    .clk, .rst,
    .data_in (ray_in.t_max),
    .data_out(t_max_d)
  );

  tuv_calc tuv0 (.clk, .rst, .prime_in(prime0), .t_max(t_max_d), .tuv_out(tuv_res0));
  tuv_calc tuv1 (.clk, .rst, .prime_in(prime1), .t_max(t_max_d), .tuv_out(tuv_res1));

  // ray, ids and valid over the whole math latency
  delay_line #(.LAT(MATH_LAT), .WIDTH($bits(int_pipe_t) + 1)) pipe_dl (
    .clk, .rst,
    .data_in (side_in),
    .data_out(side_out)
  );

  hit_select hs (
    .clk,
    .rst,
    .valid_in(valid_math),
    .tuv0    (tuv_res0),
    .tuv1    (tuv_res1),
    .pipe_in (pipe_math),
    .valid_out,
    .hit_out,
    .ray_out,
    .intersection_out
  );

endmodule

`default_nettype wire

/* int_math_properties.sv */
// int_math_properties: concurrent checks on result latency, hit gating and reset of int_math
`timescale 1ns/10ps
`default_nettype none

module int_math_properties (
  input logic clk,
  input logic rst,
  input logic valid_in,
  input logic valid_out,
  input logic hit_out
);
  import int_pkg::*;

  // every accepted ray returns INT_LAT edges later
  a_latency: assert property (@(posedge clk) disable iff (rst)
    valid_in |-> ##INT_LAT valid_out)
    else $error("valid_out missing INT_LAT cycles after valid_in");

  // nothing comes out without a ray behind it
  a_no_stray: assert property (@(posedge clk) disable iff (rst)
    valid_out |-> $past(valid_in, INT_LAT))
    else $error("valid_out without a matching valid_in");

  a_hit_gated: assert property (@(posedge clk) hit_out |-> valid_out)
    else $error("hit_out high while valid_out low");

  // cleared in reset and still low on the first free cycle
  a_reset: assert property (@(posedge clk) rst |=> !valid_out)
    else $error("valid_out high during or right after reset");

endmodule

bind int_math int_math_properties props (
  .clk(clk), .rst(rst), .valid_in(valid_in), .valid_out(valid_out), .hit_out(hit_out)
);

`default_nettype wire

/* tb_int_math.sv */
// tb_int_math drives the two-triangle intersection unit with random and directed rays
`timescale 1ns/10ps
`default_nettype none

module tb_int_math;
  import int_pkg::*;

  localparam int N_RAND      = 400;
  localparam int N_DIR       = 4;
  localparam int TIMEOUT_CYC = (N_RAND + N_DIR + INT_LAT + 20) * 2;

  // expected result and the cycle it is due
  typedef struct packed {
    int            due;
    logic          hit;
    ray_t          ray;
    intersection_t isect;
  } expect_t;

  logic           clk = 1'b0;
  logic           rst;
  logic           valid_in;
  ray_t           ray_in;
  int_cacheline_t tri0_in;
  int_cacheline_t tri1_in;
  logic           valid_out;
  logic           hit_out;
  ray_t           ray_out;
  intersection_t  intersection_out;

  expect_t     expq[$];
  logic [31:0] rng_state = 32'h7589;
  int          cyc = 0;

  int_math UUT (
    .clk, .rst, .valid_in, .ray_in, .tri0_in, .tri1_in,
    .valid_out, .hit_out, .ray_out, .intersection_out
  );

  always #10 clk = ~clk;

  // cycle count that also bounds the run
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYC) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Test failed");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // signed draw in [-2^(bits-1), 2^(bits-1))
  function automatic fix_t rand_fix(input int bits);
    logic signed [31:0] r;
    logic signed [31:0] s;
    r = next_random();
    s = r >>> (32 - bits);
    return s[15:0];
  endfunction

  // Q8.8 product through a 32 bit intermediate
  function automatic fix_t fix_product(input fix_t a, input fix_t b);
    int p;
    p = int'(a) * int'(b);
    p = p >>> 8;
    return p[15:0];
  endfunction

  // ray into unit triangle space
  function automatic prime_t model_prime(input ray_t r, input int_cacheline_t tr);
    prime_t p;
    fix_t   o [3];
    fix_t   d [3];
    fix_t   so [3];
    fix_t   sd [3];
    o = '{r.origin.x, r.origin.y, r.origin.z};
    d = '{r.dir.x, r.dir.y, r.dir.z};
    for (int i = 0; i < 3; i++) begin
      // translation only for the origin
      so[i] = tr.m[i][3];
      sd[i] = '0;
      for (int c = 0; c < 3; c++) begin
        so[i] = so[i] + fix_product(tr.m[i][c], o[c]);
        sd[i] = sd[i] + fix_product(tr.m[i][c], d[c]);
      end
    end
    p.originp.x = so[0];
    p.originp.y = so[1];
    p.originp.z = so[2];
    p.dirp.x    = sd[0];
    p.dirp.y    = sd[1];
    p.dirp.z    = sd[2];
    return p;
  endfunction

  // t from the z = 0 crossing and then u, v and the inside test
  function automatic tuv_t model_tuv(input prime_t p, input fix_t t_max);
    tuv_t res;
    fix_t noz;
    fix_t uv_sum;
    int   q;
    noz = -p.originp.z;
    q   = 0;
    if (p.dirp.z != 16'sd0) begin
      q = (int'(noz) * 256) / int'(p.dirp.z);
    end
    res.t        = q[15:0];
    res.t_valid  = (p.dirp.z != 16'sd0) && (res.t > 16'sd0) && (res.t < t_max);
    res.uv.u     = p.originp.x + fix_product(res.t, p.dirp.x);
    res.uv.v     = p.originp.y + fix_product(res.t, p.dirp.y);
    uv_sum       = res.uv.u + res.uv.v;
    res.bari_hit = (res.uv.u >= 16'sd0) && (res.uv.v >= 16'sd0) && (uv_sum <= FIX_ONE);
    return res;
  endfunction

  function automatic expect_t predict(input ray_t r, input int_cacheline_t a,
                                      input int_cacheline_t b);
    expect_t  e;
    tuv_t     res0;
    tuv_t     res1;
    logic     h0;
    logic     h1;
    hit_sel_e sel;
    res0 = model_tuv(model_prime(r, a), r.t_max);
    res1 = model_tuv(model_prime(r, b), r.t_max);
    h0   = res0.t_valid && res0.bari_hit;
    h1   = res1.t_valid && res1.bari_hit;
    // nearer hit wins and tri0 takes a tie
    if (h0 && (!h1 || res0.t <= res1.t)) begin
      sel = SEL_TRI0;
    end else if (h1) begin
      sel = SEL_TRI1;
    end else begin
      sel = SEL_NONE;
    end
    e       = '0;
    e.ray   = r;
    e.hit   = (sel != SEL_NONE);
    if (sel == SEL_TRI0) begin
      e.isect.tri_id = a.tri_id;
      e.isect.t_int  = res0.t;
      e.isect.uv     = res0.uv;
    end else if (sel == SEL_TRI1) begin
      e.isect.tri_id = b.tri_id;
      e.isect.t_int  = res1.t;
      e.isect.uv     = res1.uv;
    end
    if (e.hit) begin
      e.isect.p_int.x = r.origin.x + fix_product(e.isect.t_int, r.dir.x);
      e.isect.p_int.y = r.origin.y + fix_product(e.isect.t_int, r.dir.y);
      e.isect.p_int.z = r.origin.z + fix_product(e.isect.t_int, r.dir.z);
    end
    return e;
  endfunction

  task automatic stop_on_error();
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_ray(input string name, input ray_t exp, input ray_t act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_isect(input string name, input intersection_t exp,
                             input intersection_t act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      stop_on_error();
    end
  endtask

  // results checked on the falling edge
  always @(negedge clk) begin
    expect_t e;
    if (valid_out !== 1'b1) begin
      check_flag("valid_out", 1'b0, valid_out);
      check_flag("hit_out", 1'b0, hit_out);
    end else if (expq.size() == 0) begin
      $display("valid_out went high with no ray in flight at cycle %0d", cyc);
      stop_on_error();
    end else begin
      e = expq.pop_front();
      if (cyc != e.due) begin
        $display("ray %0d came out at cycle %0d, due at %0d", e.ray.ray_id, cyc, e.due);
        stop_on_error();
      end else begin
        check_ray("ray_out", e.ray, ray_out);
        check_flag("hit_out", e.hit, hit_out);
        check_isect("intersection_out", e.isect, intersection_out);
      end
    end
  end

  // drive one cycle and queue the expected result of an accepted ray
  task automatic drive_cycle(input logic v, input ray_t r, input int_cacheline_t a,
                             input int_cacheline_t b);
    expect_t e;
    valid_in = v;
    ray_in   = r;
    tri0_in  = a;
    tri1_in  = b;
    if (v) begin
      e     = predict(r, a, b);
      e.due = cyc + INT_LAT;
      expq.push_back(e);
    end
    @(posedge clk);
    #2;
  endtask

  // aligned gives a unit scale triangle with a small offset that rays often hit
  function automatic int_cacheline_t random_tri(input logic aligned);
    int_cacheline_t t;
    logic [31:0]    s;
    t = '0;
    if (aligned) begin
      for (int i = 0; i < 3; i++) begin
        t.m[i][i] = FIX_ONE;
      end
      t.m[0][3] = rand_fix(8);
      t.m[1][3] = rand_fix(8);
      t.m[2][3] = rand_fix(9);
    end else begin
      for (int i = 0; i < 3; i++) begin
        for (int c = 0; c < 4; c++) begin
          t.m[i][c] = rand_fix(10);
        end
      end
    end
    s        = next_random();
    t.tri_id = s[15:0];
    return t;
  endfunction

  function automatic ray_t random_ray(input int id);
    ray_t        r;
    logic [31:0] s;
    r.origin.x = rand_fix(9);
    r.origin.y = rand_fix(9);
    r.origin.z = rand_fix(11);
    r.dir.x    = rand_fix(8);
    r.dir.y    = rand_fix(8);
    r.dir.z    = rand_fix(10);
    s          = next_random();
    // now and then parallel to the plane
    if (s[2:0] == 3'd0) begin
      r.dir.z = '0;
    end
    r.t_max  = {4'h0, s[15:4]};
    r.ray_id = id[7:0];
    return r;
  endfunction

  task automatic run_directed();
    ray_t           r;
    int_cacheline_t a;
    int_cacheline_t b;
    r          = '0;
    r.origin.x = 16'sd64;
    r.origin.y = 16'sd64;
    r.origin.z = -16'sd512;
    r.dir.z    = FIX_ONE;
    r.t_max    = 16'sh7fff;
    a          = '0;
    for (int i = 0; i < 3; i++) begin
      a.m[i][i] = FIX_ONE;
    end
    a.tri_id = 16'h00a0;
    b        = a;
    b.tri_id = 16'h00b1;
    // tri1 at t 1.0 and tri0 at t 2.0
    b.m[2][3] = 16'sd256;
    r.ray_id  = 8'hd0;
    drive_cycle(1'b1, r, a, b);
    // both on the same plane for a tie
    b.m[2][3] = '0;
    r.ray_id  = 8'hd1;
    drive_cycle(1'b1, r, a, b);
    // tri0 pushed out in x so only tri1 hits
    a.m[0][3] = 16'sd512;
    r.ray_id  = 8'hd2;
    drive_cycle(1'b1, r, a, b);
    // parallel ray misses both
    r.dir.z  = '0;
    r.ray_id = 8'hd3;
    drive_cycle(1'b1, r, a, b);
    drive_cycle(1'b0, '0, '0, '0);
  endtask

  initial begin
    ray_t           r;
    int_cacheline_t a;
    int_cacheline_t b;
    logic [31:0]    s;
    logic           v;
    rst      = 1'b1;
    valid_in = 1'b0;
    ray_in   = '0;
    tri0_in  = '0;
    tri1_in  = '0;
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    // a few idle cycles before the first ray
    repeat (4) drive_cycle(1'b0, '0, '0, '0);
    // about 70 percent valid with aligned and random triangles mixed
    for (int n = 0; n < N_RAND; n++) begin
      s = next_random();
      v = ((s % 10) < 7);
      r = random_ray(n);
      a = random_tri(s[8:7] != 2'b00);
      b = random_tri(s[10:9] != 2'b00);
      drive_cycle(v, r, a, b);
    end
    run_directed();
    // drain and then watch for stray results
    while (expq.size() != 0) @(posedge clk);
    repeat (INT_LAT + 2) @(posedge clk);
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
int_pkg.sv
delay_line.sv
prime_calc.sv
tuv_calc.sv
hit_select.sv
int_math.sv
int_math_properties.sv
tb_int_math.sv

/* Makefile */
# Verilator build and run for the intersection unit testbench

VERILATOR ?= verilator
TOP       ?= tb_int_math
FILELIST  ?= tb.f
FLAGS     ?= --assert --timing
PASS_MSG  ?= Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only if the run prints the pass message
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | awk '{ print } /$(PASS_MSG)/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
